// File: sim/lsu_golden.txt
# D <L|S> <tag> <addr> <payload: rd for a load, data for a store>, all hex
# E <tag> <expected load data>; T <test number> closes a test
# test 1: loads from untouched words
D L 00 01 00000001
D L 01 3f 00000002
E 00 00000000
E 01 00000000
T 1
# test 2: forwarding from uncommitted stores
D S 00 05 11111111
D L 01 05 00000003
D S 02 06 22222222
D L 03 06 00000004
E 01 11111111
E 03 22222222
T 2
# test 3: youngest of several older stores
D S 00 0a a0000001
D S 01 0a a0000002
D S 02 0b b0000001
D S 03 0a a0000003
D L 04 0a 00000005
D S 05 0a a0000004
D L 06 0b 00000006
E 04 a0000003
E 06 b0000001
T 3
# test 4: stores dispatched after a load stay invisible to it
D L 00 0c 00000007
D S 01 0c cccc0001
D L 02 05 00000008
D S 03 05 55550001
D L 04 0c 00000009
E 00 00000000
E 02 11111111
E 04 cccc0001
T 4
# test 5: retired stores read back from the cache
D L 00 05 0000000a
D L 01 0c 0000000b
D L 02 0a 0000000c
D L 03 06 0000000d
E 00 55550001
E 01 cccc0001
E 02 a0000004
E 03 22222222
T 5
# test 6: interleaved loads and stores finishing together
D L 00 10 0000000e
D S 01 10 10101010
D L 02 10 0000000f
D S 03 11 11111110
D L 04 11 00000010
D S 05 10 10101011
D L 06 10 00000011
D S 07 12 12121212
D L 08 12 00000012
E 00 00000000
E 02 10101010
E 04 11111110
E 06 10101011
E 08 12121212
T 6

// File: project.f
+incdir+src
src/lsu_pkg.sv
src/lsu_dcache.sv
src/lsu_ldq.sv
src/lsu_stq.sv
src/lsu_done_merge.sv
src/lsu_top.sv
sim/lsu_checker.sv
sim/lsu_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps
TOP      = lsu_tb
FILELIST = project.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: sim/lsu_tb.sv
`include "lsu_cfg.svh"

module lsu_tb
  import lsu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int    RESET_CYCLES = 4;
  localparam int    CLEAR_CYCLES = 1 << `LSU_ADDR_W;  // Cache clears one word per cycle
  localparam int    MAX_OPS      = 256;
  localparam string GOLDEN       = "sim/lsu_golden.txt";

  typedef struct packed {
    logic                   is_end;
    logic                   is_load;
    logic [`LSU_TAG_W-1:0]  tag;
    logic [`LSU_ADDR_W-1:0] addr;
    logic [`LSU_DATA_W-1:0] payload;
    logic [`LSU_DATA_W-1:0] expect_data;
    logic [7:0]             test_id;
  } op_t;

  logic                         clk;
  logic                         reset_n;
  disp_t                        disp;
  commit_t                      commit;
  done_rpt_t                    done;
  done_rpt_t                    expect_rpt;
  logic                         test_end;
  int                           test_id;
  logic [(1 << `LSU_TAG_W)-1:0] seen;
  int                           errors;
  int                           tests_run;
  int                           tests_failed;
  int                           checked;

  op_t                   ops [MAX_OPS];
  int                    n_ops;
  int                    n_tests;
  int                    n_lines;
  int                    limit;
  int                    cycle_count;
  logic [31:0]           lfsr;
  logic [`LSU_TAG_W-1:0] commit_q [$];  // Tags in program order

  lsu_top DUT (
    .i_clk     (clk),
    .i_reset_n (reset_n),
    .i_disp    (disp),
    .i_commit  (commit),
    .o_done    (done)
  );

  lsu_checker u_checker (
    .i_clk          (clk),
    .i_reset_n      (reset_n),
    .i_commit       (commit),
    .i_done         (done),
    .i_expect       (expect_rpt),
    .i_test_end     (test_end),
    .i_test_id      (test_id),
    .o_seen         (seen),
    .o_errors       (errors),
    .o_tests_run    (tests_run),
    .o_tests_failed (tests_failed),
    .o_checked      (checked)
  );

  always #50 clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output int v);
    v = 0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_next(lfsr);
      v    = (v << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic parse_golden(output bit ok);
    int    fd;
    int    rc;
    byte   rec;
    byte   cat;
    int    tag;
    int    addr;
    int    val;
    string line;
    ok = 1'b0;
    fd = $fopen(GOLDEN, "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!$feof(fd)) begin
        rc = $fscanf(fd, " %c", rec);
        if (rc != 1) break;
        n_lines++;
        case (rec)
          "#": rc = $fgets(line, fd);
          "D": begin
            rc = $fscanf(fd, " %c %h %h %h", cat, tag, addr, val);
            ops[n_ops]         = '0;
            ops[n_ops].is_load = (cat == "L");
            ops[n_ops].tag     = `LSU_TAG_W'(tag);
            ops[n_ops].addr    = `LSU_ADDR_W'(addr);
            ops[n_ops].payload = val;
            n_ops++;
          end
          "E": begin
            rc = $fscanf(fd, " %h %h", tag, val);
            for (int i = n_ops - 1; i >= 0; i--) begin
              if (ops[i].is_end) break;  // Search this test only
              if (ops[i].tag == `LSU_TAG_W'(tag)) ops[i].expect_data = val;
            end
          end
          "T": begin
            rc = $fscanf(fd, " %h", val);
            ops[n_ops]         = '0;
            ops[n_ops].is_end  = 1'b1;
            ops[n_ops].test_id = 8'(val);
            n_ops++;
            n_tests++;
          end
          default: begin
            $display("Golden file holds an unknown record type '%c'", rec);
            ok = 1'b0;
          end
        endcase
      end
      $fclose(fd);
    end
  endtask

  // Inputs change 1 ns after the edge, strobes last one cycle
  task automatic next_cycle();
    @(posedge clk);
    #1;
    disp       = '0;
    expect_rpt = '0;
    test_end   = 1'b0;
  endtask

  task automatic dispatch_op(input op_t op);
    int gap;
    random_bits(2, gap);
    repeat (gap) next_cycle();
    next_cycle();
    disp.valid            = 1'b1;
    disp.cat              = op.is_load ? CAT_LD : CAT_ST;
    disp.tag              = op.tag;
    disp.addr             = op.addr;
    disp.payload.st.data  = op.payload;
    expect_rpt.valid      = 1'b1;
    expect_rpt.tag        = op.tag;
    expect_rpt.is_load    = op.is_load;
    expect_rpt.rd         = op.is_load ? op.payload[`LSU_RD_W-1:0] : '0;
    expect_rpt.data       = op.is_load ? op.expect_data : '0;  // Stores report zero
    commit_q.push_back(op.tag);
  endtask

  task automatic close_test(input int id);
    do begin
      next_cycle();
    end while (commit_q.size() != 0);
    next_cycle();  // Last commit and cache write land
    next_cycle();
    test_end = 1'b1;
    test_id  = id;
  endtask

  // ------------------------------------------------------------------------
  // Commit driver, oldest tag once its report has been seen
  // ------------------------------------------------------------------------
  initial begin
    forever begin
      @(posedge clk);
      #1;
      commit = '0;
      if (commit_q.size() != 0) begin
        if (seen[commit_q[0]]) begin
          commit.valid = 1'b1;
          commit.tag   = commit_q.pop_front();
        end
      end
    end
  end

  initial begin
    cycle_count = 0;
    wait (limit != 0);
    while (cycle_count < limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Run stopped after %0d cycles without finishing the golden tests", limit);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    bit ok;
    clk        = 1'b0;
    reset_n    = 1'b0;
    disp       = '0;
    commit     = '0;
    expect_rpt = '0;
    test_end   = 1'b0;
    test_id    = 0;
    lfsr       = 32'hdaaba1df;
    n_ops      = 0;
    n_tests    = 0;
    n_lines    = 0;
    parse_golden(ok);
    limit = 20 * n_lines + 200;
    if (!ok) begin
      $display("Golden file %s could not be read", GOLDEN);
    end else begin
      repeat (RESET_CYCLES + CLEAR_CYCLES) @(posedge clk);
      #1;
      reset_n = 1'b1;
      for (int k = 0; k < n_ops; k++) begin
        if (ops[k].is_end) close_test(int'(ops[k].test_id));
        else dispatch_op(ops[k]);
      end
      next_cycle();
      next_cycle();
    end
    $display("tests run %0d, failed %0d, reports checked %0d, errors %0d",
             tests_run, tests_failed, checked, errors);
    if (ok && errors == 0 && tests_failed == 0 && tests_run == n_tests) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: sim/lsu_checker.sv
`include "lsu_cfg.svh"

module lsu_checker
  import lsu_pkg::*;
(
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  commit_t                       i_commit,
  input  done_rpt_t                     i_done,
  input  done_rpt_t                     i_expect,   // Expected report, sent at dispatch
  input  logic                          i_test_end,
  input  int                            i_test_id,
  output logic [(1 << `LSU_TAG_W)-1:0]  o_seen,
  output int                            o_errors,
  output int                            o_tests_run,
  output int                            o_tests_failed,
  output int                            o_checked
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TAGS = 1 << `LSU_TAG_W;

  done_rpt_t       exp_rpt [TAGS];
  logic [TAGS-1:0] open_exp;  // Dispatched, no report yet
  int              test_errs;
  int              test_rpts;

  task automatic count_error();
    o_errors++;
    test_errs++;
  endtask

  task automatic check_report(input done_rpt_t got);
    done_rpt_t want;
    want = exp_rpt[got.tag];
    if (!open_exp[got.tag]) begin
      $display("Tag %0d was reported done at %0d ns but no dispatch was waiting for it",
               got.tag, $time);
      count_error();
    end else begin
      o_checked++;
      test_rpts++;
      open_exp[got.tag] = 1'b0;
      o_seen[got.tag]   = 1'b1;
      if (got.is_load !== want.is_load) begin
        $display("[ERROR] %0d ns: tag %0d is_load %0b, expected %0b",
                 $time, got.tag, got.is_load, want.is_load);
        count_error();
      end else if (got.rd !== want.rd || got.data !== want.data) begin
        $display("[ERROR] %0d ns: tag %0d rd %0d data %h, expected rd %0d data %h",
                 $time, got.tag, got.rd, got.data, want.rd, want.data);
        count_error();
      end
    end
  endtask

  task automatic finish_test();
    if (open_exp != '0) begin
      $display("Test %0d ended with %0d dispatched tags never reported done",
               i_test_id, $countones(open_exp));
      count_error();
    end
    open_exp = '0;
    o_tests_run++;
    if (test_errs == 0) begin
      $display("test %0d: passed, %0d reports", i_test_id, test_rpts);
    end else begin
      o_tests_failed++;
      $display("test %0d: failed, %0d errors in %0d reports", i_test_id, test_errs, test_rpts);
    end
    test_errs = 0;
    test_rpts = 0;
  endtask

  // ------------------------------------------------------------------------
  // Sample once per cycle, DUT outputs are stable at the edge
  // ------------------------------------------------------------------------
  always @(posedge i_clk) begin
    if (!i_reset_n) begin
      o_seen         = '0;
      open_exp       = '0;
      o_errors       = 0;
      o_tests_run    = 0;
      o_tests_failed = 0;
      o_checked      = 0;
      test_errs      = 0;
      test_rpts      = 0;
    end else begin
      if (i_expect.valid) begin
        exp_rpt[i_expect.tag]  = i_expect;
        open_exp[i_expect.tag] = 1'b1;
        o_seen[i_expect.tag]   = 1'b0;
      end
      if (i_commit.valid) o_seen[i_commit.tag] = 1'b0;  // Tag free for reuse
      if (i_done.valid) check_report(i_done);
      if (i_test_end) finish_test();
    end
  end

endmodule

// File: src/lsu_top.sv
`include "lsu_cfg.svh"

module lsu_top
  import lsu_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  disp_t     i_disp,
  input  commit_t   i_commit,
  output done_rpt_t o_done
);

  stq_mask_t              w_stq_mask;
  fwd_req_t               w_fwd_req;
  fwd_resp_t              w_fwd_resp;
  logic [`LSU_ADDR_W-1:0] w_rd_addr;
  logic [`LSU_DATA_W-1:0] w_rd_data;
  logic                   w_wr_en;
  logic [`LSU_ADDR_W-1:0] w_wr_addr;
  logic [`LSU_DATA_W-1:0] w_wr_data;
  done_rpt_t              w_ld_done;
  done_rpt_t              w_st_done;
  logic                   w_st_grant;

  // ------------------------------------------------------------------------
  // Load and store queues
  // ------------------------------------------------------------------------
  lsu_ldq u_ldq (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_disp     (i_disp),
    .i_commit   (i_commit),
    .i_stq_mask (w_stq_mask),
    .o_fwd_req  (w_fwd_req),
    .i_fwd_resp (w_fwd_resp),
    .o_rd_addr  (w_rd_addr),
    .i_rd_data  (w_rd_data),
    .o_done     (w_ld_done)
  );

  lsu_stq u_stq (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp       (i_disp),
    .i_commit     (i_commit),
    .o_valid_mask (w_stq_mask),
    .i_fwd_req    (w_fwd_req),
    .o_fwd_resp   (w_fwd_resp),
    .o_done       (w_st_done),
    .i_st_grant   (w_st_grant),
    .o_wr_en      (w_wr_en),
    .o_wr_addr    (w_wr_addr),
    .o_wr_data    (w_wr_data)
  );

  // ------------------------------------------------------------------------
  // Data array and completion port
  // ------------------------------------------------------------------------
  lsu_dcache u_dcache (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_rd_addr (w_rd_addr),
    .o_rd_data (w_rd_data),
    .i_wr_en   (w_wr_en),
    .i_wr_addr (w_wr_addr),
    .i_wr_data (w_wr_data)
  );

  lsu_done_merge u_done_merge (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_ld_done  (w_ld_done),
    .i_st_done  (w_st_done),
    .o_st_grant (w_st_grant),
    .o_done     (o_done)
  );

endmodule

// File: src/lsu_done_merge.sv
module lsu_done_merge
  import lsu_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  done_rpt_t i_ld_done,
  input  done_rpt_t i_st_done,
  output logic      o_st_grant,
  output done_rpt_t o_done
);

  done_rpt_t r_done;

  // Loads always win, the store side retries
  assign o_st_grant = i_st_done.valid && !i_ld_done.valid;

  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      r_done <= '0;
    end else if (i_ld_done.valid) begin
      r_done <= i_ld_done;
    end else begin
      r_done <= i_st_done;  // Valid low when nothing is pending
    end
  end

  assign o_done = r_done;

endmodule

// File: src/lsu_stq.sv
`include "lsu_cfg.svh"

module lsu_stq
  import lsu_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  disp_t                  i_disp,
  input  commit_t                i_commit,
  output stq_mask_t              o_valid_mask,
  input  fwd_req_t               i_fwd_req,
  output fwd_resp_t              o_fwd_resp,
  output done_rpt_t              o_done,
  input  logic                   i_st_grant,
  output logic                   o_wr_en,
  output logic [`LSU_ADDR_W-1:0] o_wr_addr,
  output logic [`LSU_DATA_W-1:0] o_wr_data
);

  localparam int IDX_W = $clog2(`LSU_STQ_N);

  stq_mask_t              r_valid;
  stq_mask_t              r_rptd;
  logic [IDX_W-1:0]       r_head;
  logic [IDX_W-1:0]       r_tail;
  logic [IDX_W-1:0]       r_rpt;  // Next store to report
  logic [`LSU_TAG_W-1:0]  r_tag  [`LSU_STQ_N];
  logic [`LSU_ADDR_W-1:0] r_addr [`LSU_STQ_N];
  logic [`LSU_DATA_W-1:0] r_data [`LSU_STQ_N];

  logic                   w_alloc;
  logic                   w_retire;
  logic                   w_rpt_valid;
  stq_mask_t              w_match;
  logic [IDX_W-1:0]       w_idx;
  logic                   w_fwd_hit;
  logic [`LSU_DATA_W-1:0] w_fwd_data;

  logic                   r_wr_en;
  logic [`LSU_ADDR_W-1:0] r_wr_addr;
  logic [`LSU_DATA_W-1:0] r_wr_data;

  assign w_alloc      = i_disp.valid && (i_disp.cat == CAT_ST);
  assign w_retire     = i_commit.valid && r_valid[r_head] && (r_tag[r_head] == i_commit.tag);
  assign w_rpt_valid  = r_valid[r_rpt] && !r_rptd[r_rpt];
  assign o_valid_mask = r_valid;

  // ------------------------------------------------------------------------
  // Store-to-load forwarding
  // ------------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < `LSU_STQ_N; i++) begin
      w_match[i] = r_valid[i] && i_fwd_req.mask[i] && (r_addr[i] == i_fwd_req.addr);
    end
  end

  // Walk back from the tail, first match is the youngest older store
  always_comb begin
    w_idx      = r_tail;
    w_fwd_hit  = 1'b0;
    w_fwd_data = '0;
    for (int k = 1; k <= `LSU_STQ_N; k++) begin
      w_idx = r_tail - IDX_W'(k);
      if (i_fwd_req.valid && !w_fwd_hit && w_match[w_idx]) begin
        w_fwd_hit  = 1'b1;
        w_fwd_data = r_data[w_idx];
      end
    end
  end

  assign o_fwd_resp = '{hit: w_fwd_hit, data: w_fwd_data};

  // ------------------------------------------------------------------------
  // Done report, held until the merger grants it
  // ------------------------------------------------------------------------
  assign o_done = '{valid:   w_rpt_valid,
                    tag:     r_tag[r_rpt],
                    is_load: 1'b0,
                    rd:      '0,
                    data:    '0};

  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      r_valid <= '0;
      r_rptd  <= '0;
      r_head  <= '0;
      r_tail  <= '0;
      r_rpt   <= '0;
      r_wr_en <= 1'b0;
    end else begin
      r_wr_en <= w_retire;
      if (w_alloc) begin
        r_valid[r_tail] <= 1'b1;
        r_rptd[r_tail]  <= 1'b0;
        r_tail          <= r_tail + 1'b1;
      end
      if (w_rpt_valid && i_st_grant) begin
        r_rptd[r_rpt] <= 1'b1;
        r_rpt         <= r_rpt + 1'b1;
      end
      if (w_retire) begin
        r_valid[r_head] <= 1'b0;
        r_head          <= r_head + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_alloc) begin
      r_tag[r_tail]  <= i_disp.tag;
      r_addr[r_tail] <= i_disp.addr;
      r_data[r_tail] <= i_disp.payload.st.data;
    end
    if (w_retire) begin
      r_wr_addr <= r_addr[r_head];
      r_wr_data <= r_data[r_head];
    end
  end

  // Write lands the cycle after commit
  assign o_wr_en   = r_wr_en;
  assign o_wr_addr = r_wr_addr;
  assign o_wr_data = r_wr_data;

endmodule

// File: src/lsu_ldq.sv
`include "lsu_cfg.svh"

module lsu_ldq
  import lsu_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  disp_t                  i_disp,
  input  commit_t                i_commit,
  input  stq_mask_t              i_stq_mask,
  output fwd_req_t               o_fwd_req,
  input  fwd_resp_t              i_fwd_resp,
  output logic [`LSU_ADDR_W-1:0] o_rd_addr,
  input  logic [`LSU_DATA_W-1:0] i_rd_data,
  output done_rpt_t              o_done
);

  localparam int IDX_W = $clog2(`LSU_LDQ_N);

  logic [`LSU_LDQ_N-1:0]  r_valid;
  logic [`LSU_LDQ_N-1:0]  r_issued;
  logic [`LSU_LDQ_N-1:0]  r_rptd;
  stq_mask_t              r_mask  [`LSU_LDQ_N];
  logic [`LSU_TAG_W-1:0]  r_tag   [`LSU_LDQ_N];
  logic [`LSU_ADDR_W-1:0] r_addr  [`LSU_LDQ_N];
  logic [`LSU_RD_W-1:0]   r_rd    [`LSU_LDQ_N];
  logic [`LSU_LDQ_N-1:0]  r_older [`LSU_LDQ_N];  // Row i: slots older than i

  logic                   w_alloc;
  logic [IDX_W-1:0]       w_free_idx;
  logic [`LSU_LDQ_N-1:0]  w_cand;
  logic                   w_issue;
  logic [IDX_W-1:0]       w_issue_idx;
  logic [`LSU_LDQ_N-1:0]  w_free;

  logic                   r_s1_valid;
  logic [IDX_W-1:0]       r_s1_idx;
  logic                   r_s1_hit;
  logic [`LSU_DATA_W-1:0] r_s1_fwd_data;

  assign w_alloc = i_disp.valid && (i_disp.cat == CAT_LD);
  assign w_cand  = r_valid & ~r_issued;

  // Lowest free slot
  always_comb begin
    w_free_idx = '0;
    for (int i = `LSU_LDQ_N - 1; i >= 0; i--) begin
      if (!r_valid[i]) w_free_idx = IDX_W'(i);
    end
  end

  // Oldest unissued load, no older candidate in its row
  always_comb begin
    w_issue     = 1'b0;
    w_issue_idx = '0;
    for (int i = 0; i < `LSU_LDQ_N; i++) begin
      if (w_cand[i] && ((r_older[i] & w_cand) == '0)) begin
        w_issue     = 1'b1;
        w_issue_idx = IDX_W'(i);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `LSU_LDQ_N; i++) begin
      w_free[i] = i_commit.valid && r_valid[i] && r_rptd[i] && (r_tag[i] == i_commit.tag);
    end
  end

  assign o_fwd_req = '{valid: w_issue, addr: r_addr[w_issue_idx], mask: r_mask[w_issue_idx]};
  assign o_rd_addr = r_addr[w_issue_idx];

  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      r_valid    <= '0;
      r_issued   <= '0;
      r_rptd     <= '0;
      r_s1_valid <= 1'b0;
    end else begin
      r_valid    <= r_valid & ~w_free;
      r_s1_valid <= w_issue;
      if (w_issue) r_issued[w_issue_idx] <= 1'b1;
      if (r_s1_valid) r_rptd[r_s1_idx] <= 1'b1;
      if (w_alloc) begin
        r_valid[w_free_idx]  <= 1'b1;
        r_issued[w_free_idx] <= 1'b0;
        r_rptd[w_free_idx]   <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    for (int i = 0; i < `LSU_LDQ_N; i++) begin
      r_mask[i] <= r_mask[i] & i_stq_mask;  // Retired stores drop out
    end
    if (w_alloc) begin
      r_mask[w_free_idx] <= i_stq_mask;
      r_tag[w_free_idx]  <= i_disp.tag;
      r_addr[w_free_idx] <= i_disp.addr;
      r_rd[w_free_idx]   <= i_disp.payload.ld.rd;
      for (int i = 0; i < `LSU_LDQ_N; i++) begin
        r_older[i][w_free_idx] <= 1'b0;
      end
      r_older[w_free_idx] <= r_valid;  // Everything already here is older
    end
    r_s1_idx      <= w_issue_idx;
    r_s1_hit      <= i_fwd_resp.hit;
    r_s1_fwd_data <= i_fwd_resp.data;
  end

  // Cache data lands this cycle, forward result was registered
  assign o_done = '{valid:   r_s1_valid,
                    tag:     r_tag[r_s1_idx],
                    is_load: 1'b1,
                    rd:      r_rd[r_s1_idx],
                    data:    r_s1_hit ? r_s1_fwd_data : i_rd_data};

endmodule

// File: src/lsu_dcache.sv
`include "lsu_cfg.svh"

module lsu_dcache (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic [`LSU_ADDR_W-1:0] i_rd_addr,
  output logic [`LSU_DATA_W-1:0] o_rd_data,
  input  logic                   i_wr_en,
  input  logic [`LSU_ADDR_W-1:0] i_wr_addr,
  input  logic [`LSU_DATA_W-1:0] i_wr_data
);

  localparam int WORDS = 1 << `LSU_ADDR_W;

  logic [`LSU_DATA_W-1:0] r_mem [WORDS];
  logic [`LSU_ADDR_W-1:0] r_clr_addr;  // Walks the array while in reset
  logic                   r_clr_busy;  // Set after the first reset cycle
  logic [`LSU_DATA_W-1:0] r_rd_data;

  // Clear one word per reset cycle, wraps so any start point covers all
  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      if (r_clr_busy) begin
        r_mem[r_clr_addr] <= '0;
        r_clr_addr        <= r_clr_addr + 1'b1;
      end else begin
        r_clr_addr <= '0;  // First reset cycle picks the start word
      end
      r_clr_busy <= 1'b1;
    end else begin
      r_clr_busy <= 1'b0;
      if (i_wr_en) begin
        r_mem[i_wr_addr] <= i_wr_data;
      end
    end
  end

  // Registered read, write-first on same address
  always_ff @(posedge i_clk) begin
    if (i_wr_en && (i_wr_addr == i_rd_addr)) begin
      r_rd_data <= i_wr_data;
    end else begin
      r_rd_data <= r_mem[i_rd_addr];
    end
  end

  assign o_rd_data = r_rd_data;

endmodule

// File: src/lsu_pkg.sv
`include "lsu_cfg.svh"

package lsu_pkg;

  typedef enum logic [1:0] {
    CAT_NONE = 2'd0,
    CAT_LD   = 2'd1,
    CAT_ST   = 2'd2
  } inst_cat_t;

  // Load view of the payload word
  typedef struct packed {
    logic [`LSU_DATA_W-`LSU_RD_W-1:0] pad;
    logic [`LSU_RD_W-1:0]             rd;
  } ld_payload_t;

  // Store view of the payload word
  typedef struct packed {
    logic [`LSU_DATA_W-1:0] data;
  } st_payload_t;

  typedef union packed {
    ld_payload_t ld;
    st_payload_t st;
  } disp_payload_u;

  typedef logic [`LSU_STQ_N-1:0] stq_mask_t;  // One bit per STQ slot

  typedef struct packed {
    logic                   valid;
    inst_cat_t              cat;
    logic [`LSU_TAG_W-1:0]  tag;
    logic [`LSU_ADDR_W-1:0] addr;
    disp_payload_u          payload;
  } disp_t;

  typedef struct packed {
    logic                  valid;
    logic [`LSU_TAG_W-1:0] tag;
  } commit_t;

  typedef struct packed {
    logic                   valid;
    logic [`LSU_TAG_W-1:0]  tag;
    logic                   is_load;
    logic [`LSU_RD_W-1:0]   rd;
    logic [`LSU_DATA_W-1:0] data;  // Zero for stores
  } done_rpt_t;

  typedef struct packed {
    logic                   valid;
    logic [`LSU_ADDR_W-1:0] addr;
    stq_mask_t              mask;
  } fwd_req_t;

  typedef struct packed {
    logic                   hit;
    logic [`LSU_DATA_W-1:0] data;
  } fwd_resp_t;

endpackage

// File: src/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Word address width, 64 words in the data array
`define LSU_ADDR_W 6

// Reorder tag width
`define LSU_TAG_W 5

// Queue depths
`define LSU_LDQ_N 8
`define LSU_STQ_N 8

// Data word and destination register widths
`define LSU_DATA_W 32
`define LSU_RD_W 5

`endif
